//--- hdl/limn_macros.svh
`ifndef LIMN_MACROS_SVH
`define LIMN_MACROS_SVH

//////////////////////////////
// Datapath widths
//////////////////////////////

`define LIMN_WORD_W     32  // Data and address
`define LIMN_NUM_REGS   32
`define LIMN_REG_IDX_W  5

//////////////////////////////
// Architectural constants
//////////////////////////////

// Link register for jal
`define LIMN_LINK_REG   5'd31

// First fetch address out of reset
`define LIMN_RESET_VEC  32'hFFFE0000

`endif

//--- hdl/limn_pkg.sv
`default_nettype none

`include "limn_macros.svh"

package limn_pkg;

    typedef logic [`LIMN_WORD_W-1:0]    word_t;
    typedef logic [`LIMN_REG_IDX_W-1:0] reg_idx_t;
    typedef logic [4:0]                 shamt_t;

    // Low eight codes match instruction bits 5:3 of the immediate group
    typedef enum logic [3:0] {
        alu_lui  = 4'b0000,
        alu_or   = 4'b0001,
        alu_xor  = 4'b0010,
        alu_and  = 4'b0011,
        alu_slts = 4'b0100,
        alu_slt  = 4'b0101,
        alu_sub  = 4'b0110,
        alu_add  = 4'b0111,
        alu_nor  = 4'b1000  // Register group only
    } alu_op_e;

    // Same order as instruction bits 27:26
    typedef enum logic [1:0] {
        shift_lsh = 2'b00,
        shift_rsh = 2'b01,
        shift_ash = 2'b10,
        shift_ror = 2'b11
    } shift_mode_e;

    typedef enum logic [2:0] {
        br_none,
        br_beq,
        br_bne,
        br_blt,
        br_jal,
        br_jalr
    } branch_kind_e;

    typedef enum logic [1:0] {
        mem_none,
        mem_load,
        mem_store
    } mem_kind_e;

    typedef enum logic [2:0] {
        st_fetch,
        st_execute,
        st_read,
        st_write,
        st_halt
    } core_state_e;

endpackage

`default_nettype wire

//--- hdl/limn_decode.sv
`default_nettype none

`include "limn_macros.svh"

module limn_decode (
    input  wire limn_pkg::word_t     inst,
    output limn_pkg::reg_idx_t       ra_idx,
    output limn_pkg::reg_idx_t       rb_idx,
    output limn_pkg::reg_idx_t       rd_idx,
    output logic                     rd_we,
    output limn_pkg::alu_op_e        alu_op,
    output logic                     b_use_imm,
    output limn_pkg::word_t          imm,
    output limn_pkg::shift_mode_e    shift_mode,
    output limn_pkg::shamt_t         shamt,
    output limn_pkg::branch_kind_e   branch_kind,
    output limn_pkg::word_t          branch_off,
    output logic                     link,
    output limn_pkg::mem_kind_e      mem_kind,
    output logic                     store_use_imm,
    output limn_pkg::word_t          store_imm,
    output logic                     halt,
    output logic                     fault
);
    import limn_pkg::*;

    logic [5:0]  opcode;
    logic [3:0]  op_hi;     // Group selector in bits 31:28
    reg_idx_t    op_r1;
    reg_idx_t    op_r2;
    reg_idx_t    op_r3;
    logic [15:0] imm16;
    logic [20:0] imm21;
    logic [28:0] imm29;

    assign opcode = inst[5:0];
    assign op_hi  = inst[31:28];
    assign op_r1  = inst[10:6];
    assign op_r2  = inst[15:11];
    assign op_r3  = inst[20:16];
    assign imm16  = inst[31:16];
    assign imm21  = inst[31:11];
    assign imm29  = inst[31:3];

    always_comb begin
        ra_idx        = op_r1;
        rb_idx        = op_r2;
        rd_idx        = op_r1;
        rd_we         = 1'b0;
        alu_op        = alu_add;
        b_use_imm     = 1'b1;
        imm           = '0;
        shift_mode    = shift_lsh;
        shamt         = '0;
        branch_kind   = br_none;
        branch_off    = {{9{imm21[20]}}, imm21, 2'b00};
        link          = 1'b0;
        mem_kind      = mem_none;
        store_use_imm = 1'b0;
        store_imm     = {27'b0, inst[15:11]}; // imm5 source of a store
        halt          = 1'b0;
        fault         = 1'b0;

        // Priority order matters since jal overlaps several patterns
        casez (opcode)
            6'b111000: begin // jalr rd, ra, imm16
                ra_idx      = op_r2;
                rd_we       = 1'b1;
                link        = 1'b1;
                branch_kind = br_jalr;
                branch_off  = {{14{imm16[15]}}, imm16, 2'b00};
            end
            6'b???11?: begin // jal with link requested by bit 0
                rd_idx      = `LIMN_LINK_REG;
                rd_we       = inst[0];
                link        = 1'b1;
                branch_kind = br_jal;
                branch_off  = {1'b0, imm29, 2'b00};
            end
            6'b111101: branch_kind = br_beq;
            6'b110101: branch_kind = br_bne;
            6'b101101: branch_kind = br_blt;
            6'b???100: begin // Immediate ALU group
                ra_idx = op_r2;
                rd_we  = 1'b1;
                alu_op = alu_op_e'({1'b0, opcode[5:3]});
                imm    = {16'b0, imm16};
            end
            6'b1??011: begin // Load rd, [ra + imm16]
                if (opcode[4:3] == 2'b01) begin
                    ra_idx   = op_r2;
                    mem_kind = mem_load;
                    imm      = {14'b0, imm16, 2'b00};
                end else begin
                    fault = 1'b1;   // Sub-word size
                end
            end
            6'b???010: begin // Store rb or imm5 to [ra + imm16]
                if (opcode[4:3] == 2'b01) begin
                    mem_kind      = mem_store;
                    store_use_imm = ~opcode[5];
                    imm           = {14'b0, imm16, 2'b00};
                end else begin
                    fault = 1'b1;
                end
            end
            6'b111001: begin // Register ALU group
                ra_idx     = op_r2;
                rb_idx     = op_r3;
                b_use_imm  = 1'b0;
                shift_mode = shift_mode_e'(inst[27:26]);
                shamt      = inst[25:21];
                if (op_hi == 4'b0000) begin
                    rd_we  = 1'b1;
                    alu_op = alu_nor;
                end else if (op_hi[3]) begin
                    fault = 1'b1; // Indexed moves
                end else begin
                    rd_we  = 1'b1;
                    alu_op = alu_op_e'({1'b0, op_hi[2:0]});
                end
            end
            6'b101001: begin
                if (op_hi == 4'b1100) halt = 1'b1;
                else fault = 1'b1;
            end
            default: fault = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/limn_regfile.sv
`default_nettype none

`include "limn_macros.svh"

module limn_regfile (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire limn_pkg::reg_idx_t  ra_idx,
    input  wire limn_pkg::reg_idx_t  rb_idx,
    output limn_pkg::word_t          ra_val,
    output limn_pkg::word_t          rb_val,
    input  wire logic                wr_en,
    input  wire limn_pkg::reg_idx_t  wr_idx,
    input  wire limn_pkg::word_t     wr_val
);
    import limn_pkg::*;

    word_t regs [`LIMN_NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `LIMN_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != '0)) begin
            regs[wr_idx] <= wr_val;
        end
    end

    // r0 always reads zero
    assign ra_val = (ra_idx == '0) ? '0 : regs[ra_idx];
    assign rb_val = (rb_idx == '0) ? '0 : regs[rb_idx];

endmodule

`default_nettype wire

//--- hdl/limn_alu.sv
`default_nettype none

`include "limn_macros.svh"

module limn_alu (
    input  wire limn_pkg::word_t       a,
    input  wire limn_pkg::word_t       b_reg,
    input  wire limn_pkg::word_t       imm,
    input  wire logic                  b_use_imm,
    input  wire limn_pkg::shift_mode_e shift_mode,
    input  wire limn_pkg::shamt_t      shamt,
    input  wire limn_pkg::alu_op_e     alu_op,
    output limn_pkg::word_t            result
);
    import limn_pkg::*;

    logic [2*`LIMN_WORD_W-1:0] b_ror;  // Doubled word for rotate
    word_t b_shift;
    word_t b;

    //////////////////////////////
    // Operand shifter
    //////////////////////////////

    assign b_ror = {b_reg, b_reg} >> shamt;

    always_comb begin
        case (shift_mode)
            shift_lsh: b_shift = b_reg << shamt;
            shift_rsh: b_shift = b_reg >> shamt;
            shift_ash: b_shift = word_t'($signed(b_reg) >>> shamt);
            default:   b_shift = b_ror[`LIMN_WORD_W-1:0];
        endcase
    end

    assign b = b_use_imm ? imm : b_shift;

    //////////////////////////////
    // Operation
    //////////////////////////////

    always_comb begin
        case (alu_op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_and:  result = a & b;
            alu_xor:  result = a ^ b;
            alu_or:   result = a | b;
            alu_slt:  result = {31'b0, a < b};
            alu_slts: result = {31'b0, $signed(a) < $signed(b)};
            alu_lui:  result = a | (imm << 16);  // Upper half load keeps ra bits
            alu_nor:  result = ~(a | b);
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/limn_branch.sv
`default_nettype none

`include "limn_macros.svh"

module limn_branch (
    input  wire limn_pkg::word_t        pc,
    input  wire limn_pkg::word_t        ra_val,
    input  wire limn_pkg::branch_kind_e branch_kind,
    input  wire limn_pkg::word_t        branch_off,
    output logic                        taken,
    output limn_pkg::word_t             next_pc,
    output limn_pkg::word_t             link_pc
);
    import limn_pkg::*;

    word_t seq_pc;
    word_t target;

    assign seq_pc = pc + 32'd4;

    always_comb begin
        taken  = 1'b0;
        target = pc + branch_off;   // Conditional branches are pc relative
        case (branch_kind)
            br_beq: taken = (ra_val == '0);
            br_bne: taken = (ra_val != '0);
            br_blt: taken = ra_val[`LIMN_WORD_W-1];  // Negative test only
            br_jal: begin
                taken  = 1'b1;
                // Top pc bit keeps the segment
                target = {pc[`LIMN_WORD_W-1], branch_off[`LIMN_WORD_W-2:0]};
            end
            br_jalr: begin
                taken  = 1'b1;
                target = ra_val + branch_off;
            end
            default: taken = 1'b0;
        endcase
    end

    assign next_pc = taken ? target : seq_pc;
    assign link_pc = seq_pc;

endmodule

`default_nettype wire

//--- hdl/limn_core.sv
`default_nettype none

`include "limn_macros.svh"

module limn_core (
    input  wire logic             clk,
    input  wire logic             rst,
    output limn_pkg::word_t       addr,
    input  wire limn_pkg::word_t  data_in,
    output limn_pkg::word_t       data_out,
    input  wire logic             rdy,
    output logic                  we,
    output logic                  cs,
    output logic                  halted,
    output logic                  fault
);
    import limn_pkg::*;

    core_state_e  state;
    word_t        pc;
    word_t        ir;

    reg_idx_t     ra_idx, rb_idx, rd_idx;
    logic         rd_we, b_use_imm, link, store_use_imm, dec_halt, dec_fault;
    alu_op_e      alu_op;
    word_t        imm, branch_off, store_imm;
    shift_mode_e  shift_mode;
    shamt_t       shamt;
    branch_kind_e branch_kind;
    mem_kind_e    mem_kind;

    word_t        ra_val, rb_val, alu_result, next_pc, link_pc;
    logic         wb_en;
    word_t        wb_val;

    limn_decode u_decode (
        .inst(ir), .ra_idx(ra_idx), .rb_idx(rb_idx), .rd_idx(rd_idx), .rd_we(rd_we),
        .alu_op(alu_op), .b_use_imm(b_use_imm), .imm(imm), .shift_mode(shift_mode),
        .shamt(shamt), .branch_kind(branch_kind), .branch_off(branch_off), .link(link),
        .mem_kind(mem_kind), .store_use_imm(store_use_imm), .store_imm(store_imm),
        .halt(dec_halt), .fault(dec_fault)
    );

    limn_regfile u_regfile (
        .clk(clk), .rst(rst), .ra_idx(ra_idx), .rb_idx(rb_idx), .ra_val(ra_val),
        .rb_val(rb_val), .wr_en(wb_en), .wr_idx(rd_idx), .wr_val(wb_val)
    );

    limn_alu u_alu (
        .a(ra_val), .b_reg(rb_val), .imm(imm), .b_use_imm(b_use_imm),
        .shift_mode(shift_mode), .shamt(shamt), .alu_op(alu_op), .result(alu_result)
    );

    limn_branch u_branch (
        .pc(pc), .ra_val(ra_val), .branch_kind(branch_kind), .branch_off(branch_off),
        .taken(), .next_pc(next_pc), .link_pc(link_pc)
    );

    //////////////////////////////
    // Write-back
    //////////////////////////////

    // Loads write at read completion and everything else in execute
    assign wb_en  = (state == st_read) ? (cs && rdy) : ((state == st_execute) && rd_we);
    assign wb_val = (state == st_read) ? data_in : (link ? link_pc : alu_result);

    assign halted = (state == st_halt);

    //////////////////////////////
    // Bus state machine
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_fetch;
            pc    <= `LIMN_RESET_VEC;
            addr  <= `LIMN_RESET_VEC;
            cs    <= 1'b0;
            we    <= 1'b0;
            fault <= 1'b0;
        end else begin
            case (state)
                st_fetch: begin
                    if (!cs) begin
                        cs <= 1'b1;     // First request after reset
                    end else if (rdy) begin
                        cs    <= 1'b0;
                        state <= st_execute;
                    end
                end
                st_execute: begin
                    if (dec_halt || dec_fault) begin
                        state <= st_halt;
                        fault <= dec_fault;
                    end else begin
                        pc <= next_pc;
                        cs <= 1'b1;
                        case (mem_kind)
                            mem_load: begin
                                state <= st_read;
                                addr  <= alu_result;
                            end
                            mem_store: begin
                                state <= st_write;
                                we    <= 1'b1;
                                addr  <= alu_result;
                            end
                            default: begin
                                state <= st_fetch;
                                addr  <= next_pc;
                            end
                        endcase
                    end
                end
                st_read, st_write: begin
                    if (rdy) begin  // Straight into the next fetch
                        state <= st_fetch;
                        we    <= 1'b0;
                        addr  <= pc;
                    end
                end
                default: cs <= 1'b0; // Halted until reset
            endcase
        end
    end

    // Instruction and store data
    always_ff @(posedge clk) begin
        if ((state == st_fetch) && cs && rdy) begin
            ir <= data_in;
        end
        if ((state == st_execute) && (mem_kind == mem_store)) begin
            data_out <= store_use_imm ? store_imm : rb_val;
        end
    end

endmodule

`default_nettype wire

//--- tests/tb_limn_mem.sv
`default_nettype none

`include "limn_macros.svh"

module tb_limn_mem (
    input  wire logic            clk,
    input  wire logic            stall_en,
    input  wire limn_pkg::word_t addr,
    input  wire limn_pkg::word_t data_out,
    input  wire logic            cs,
    input  wire logic            we,
    output limn_pkg::word_t      data_in,
    output logic                 rdy
);
    timeunit 1ns;
    timeprecision 100ps;
    import limn_pkg::*;

    word_t       mem [256];     // Indexed by address bits 9:2
    word_t       log_addr [64];
    word_t       log_data [64];
    int          log_count;
    logic [31:0] lfsr;
    logic        gate;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Every word decodes to an unknown encoding, so a stray fetch faults
    task automatic reset_contents();
        for (int i = 0; i < 256; i++) begin
            mem[i] = {i[7:0], 8'h5A, ~i[7:0], 8'hC3};
        end
        log_count = 0;
    endtask

    task automatic load_word(input int idx, input word_t val);
        mem[idx] = val;
    endtask

    initial begin
        rdy       = 1'b0;
        data_in   = '0;
        log_count = 0;
        lfsr      = 32'h919c;
    end

    always @(posedge clk) begin
        if (cs && we && rdy) begin  // Write completes on this edge
            mem[addr[9:2]] = data_out;
            if (log_count < 64) begin
                log_addr[log_count] = addr;
                log_data[log_count] = data_out;
            end
            log_count++;
        end
        #1;
        gate = 1'b1;
        if (stall_en && cs) begin
            lfsr = lfsr_next(lfsr);
            gate = lfsr[0];         // Low bit stalls the cycle
        end
        rdy     = cs && gate;
        data_in = mem[addr[9:2]];
    end

endmodule

`default_nettype wire

//--- tests/tb_limn_core.sv
`default_nettype none

`include "limn_macros.svh"

module tb_limn_core;
    timeunit 1ns;
    timeprecision 100ps;
    import limn_pkg::*;

    localparam word_t BASE = `LIMN_RESET_VEC;
    localparam logic [5:0] OP_LUI = 6'b000100, OP_ORI = 6'b001100, OP_XORI = 6'b010100;
    localparam logic [5:0] OP_ANDI = 6'b011100, OP_SLTSI = 6'b100100, OP_SLTI = 6'b101100;
    localparam logic [5:0] OP_SUBI = 6'b110100, OP_ADDI = 6'b111100, OP_LD = 6'b101011;
    localparam logic [5:0] OP_ST = 6'b101010, OP_STI = 6'b001010, OP_JALR = 6'b111000;
    localparam logic [5:0] OP_BEQ = 6'b111101, OP_BNE = 6'b110101, OP_BLT = 6'b101101;
    localparam word_t HLT = 32'hC0000029;

    logic  clk, rst, stall_en, rdy, we, cs, halted, fault;
    word_t addr, data_in, data_out;
    word_t exp_addr [$];
    word_t exp_data [$];
    int    pc_idx;

    initial clk = 1'b0;
    always #4 clk = ~clk;

    limn_core UUT (
        .clk(clk), .rst(rst), .addr(addr), .data_in(data_in), .data_out(data_out),
        .rdy(rdy), .we(we), .cs(cs), .halted(halted), .fault(fault)
    );

    tb_limn_mem mem_i (
        .clk(clk), .stall_en(stall_en), .addr(addr), .data_out(data_out), .cs(cs),
        .we(we), .data_in(data_in), .rdy(rdy)
    );

    task automatic fail_with(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_word(input string what, input word_t exp, input word_t act);
        assert (act === exp) else begin
            $display("ERR %s expected %h actual %h", what, exp, act);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    //////////////////////////////
    // Bus protocol properties
    //////////////////////////////

    a_reset_idle: assert property (@(posedge clk) rst |=> (!cs && !we && !halted && !fault))
        else fail_with("Bus or status active right after a reset cycle");
    a_hold: assert property (@(posedge clk) disable iff (rst)
        (cs && !rdy) |=> ($stable(addr) && $stable(we) && $stable(data_out)))
        else fail_with("Request changed while stalled");
    a_halt_quiet: assert property (@(posedge clk) disable iff (rst) halted |-> !cs)
        else fail_with("Request issued while halted");

    //////////////////////////////
    // Encoders
    //////////////////////////////

    function automatic word_t ifmt(input logic [15:0] imm, input reg_idx_t f2,
                                   input reg_idx_t f1, input logic [5:0] op);
        return {imm, f2, f1, op};
    endfunction

    function automatic word_t rfmt(input logic [3:0] hi, input logic [1:0] mode,
                                   input shamt_t sh, input reg_idx_t rb,
                                   input reg_idx_t ra, input reg_idx_t rd);
        return {hi, mode, sh, rb, ra, rd, 6'b111001};
    endfunction

    function automatic word_t bfmt(input int off, input reg_idx_t ra, input logic [5:0] op);
        return {21'(off), ra, op};  // Offset in words from the branch
    endfunction

    function automatic word_t jfmt(input word_t target, input logic lnk);
        return {target[30:2], 2'b11, lnk};
    endfunction

    task automatic start_program();
        mem_i.reset_contents();
        pc_idx = 0;
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic emit(input word_t w);
        mem_i.load_word(pc_idx, w);
        pc_idx++;
    endtask

    task automatic expect_store(input word_t a, input word_t d);
        exp_addr.push_back(a);
        exp_data.push_back(d);
    endtask

    //////////////////////////////
    // Programs
    //////////////////////////////

    task automatic build_alu();
        word_t v [15];
        start_program();
        v[1]  = (32'h8123 << 16) | 32'h4567;
        v[2]  = 32'd5;
        v[3]  = v[2] - 32'd7;
        v[4]  = v[1] ^ 32'h00FF;
        v[5]  = v[1] & 32'h0FF0;
        v[6]  = {31'b0, v[3] < 32'd1};
        v[7]  = {31'b0, $signed(v[3]) < 32'sd1};
        v[8]  = v[2] + (v[1] << 4);
        v[9]  = v[1] >> 8;
        v[10] = $signed(v[1]) >>> 8;
        v[11] = (v[1] >> 12) | (v[1] << 20);   // Rotate right by 12
        v[12] = ~(v[2] | v[5]);
        v[13] = {31'b0, v[3] < v[2]};
        v[14] = {31'b0, $signed(v[3]) < $signed(v[2])};
        emit(ifmt(16'h8123, 5'd0, 5'd1, OP_LUI));
        emit(ifmt(16'h4567, 5'd1, 5'd1, OP_ORI));
        emit(ifmt(16'd5, 5'd0, 5'd2, OP_ADDI));
        emit(ifmt(16'd7, 5'd2, 5'd3, OP_SUBI));
        emit(ifmt(16'h00FF, 5'd1, 5'd4, OP_XORI));
        emit(ifmt(16'h0FF0, 5'd1, 5'd5, OP_ANDI));
        emit(ifmt(16'd1, 5'd3, 5'd6, OP_SLTI));
        emit(ifmt(16'd1, 5'd3, 5'd7, OP_SLTSI));
        emit(rfmt(4'd7, 2'd0, 5'd4, 5'd1, 5'd2, 5'd8));    // add with lsh
        emit(rfmt(4'd1, 2'd1, 5'd8, 5'd1, 5'd0, 5'd9));    // or with rsh
        emit(rfmt(4'd1, 2'd2, 5'd8, 5'd1, 5'd0, 5'd10));   // or with ash
        emit(rfmt(4'd1, 2'd3, 5'd12, 5'd1, 5'd0, 5'd11));  // or with ror
        emit(rfmt(4'd0, 2'd0, 5'd0, 5'd5, 5'd2, 5'd12));   // nor
        emit(rfmt(4'd5, 2'd0, 5'd0, 5'd2, 5'd3, 5'd13));
        emit(rfmt(4'd4, 2'd0, 5'd0, 5'd2, 5'd3, 5'd14));
        for (int k = 1; k < 15; k++) begin
            emit(ifmt(16'(128 + k), 5'(k), 5'd0, OP_ST));
            expect_store(word_t'(512 + 4 * k), v[k]);
        end
        emit(HLT);
    endtask

    task automatic build_mem();
        word_t d;
        start_program();
        d = 32'h13579BDF;
        mem_i.load_word(8'h80, d);
        emit(ifmt(16'h80, 5'd0, 5'd1, OP_LD));
        emit(ifmt(16'd1, 5'd1, 5'd1, OP_ADDI));
        emit(ifmt(16'h81, 5'd1, 5'd0, OP_ST));
        emit(ifmt(16'h200, 5'd0, 5'd2, OP_ADDI));
        emit(ifmt(16'd2, 5'd1, 5'd2, OP_ST));      // Register base
        emit(ifmt(16'd3, 5'd21, 5'd2, OP_STI));    // imm5 data
        emit(ifmt(16'd1, 5'd2, 5'd3, OP_LD));      // Reads back the first store
        emit(ifmt(16'h84, 5'd3, 5'd0, OP_ST));
        emit(HLT);
        expect_store(32'h204, d + 1);
        expect_store(32'h208, d + 1);
        expect_store(32'h20C, 32'd21);
        expect_store(32'h210, d + 1);
    endtask

    task automatic build_branch();
        start_program();
        emit(ifmt(16'd3, 5'd0, 5'd1, OP_ADDI));
        emit(ifmt(16'd0, 5'd0, 5'd2, OP_ADDI));
        emit(ifmt(16'h10, 5'd2, 5'd2, OP_ADDI));   // Loop body
        emit(ifmt(16'd1, 5'd1, 5'd1, OP_SUBI));
        emit(bfmt(-2, 5'd1, OP_BNE));
        emit(ifmt(16'h90, 5'd2, 5'd0, OP_ST));
        emit(bfmt(2, 5'd1, OP_BEQ));
        emit(ifmt(16'h91, 5'd31, 5'd0, OP_STI));   // Skipped
        emit(bfmt(2, 5'd2, OP_BEQ));
        emit(ifmt(16'h92, 5'd2, 5'd0, OP_STI));
        emit(ifmt(16'd1, 5'd0, 5'd3, OP_SUBI));
        emit(bfmt(2, 5'd3, OP_BLT));
        emit(ifmt(16'h93, 5'd30, 5'd0, OP_STI));   // Skipped
        emit(bfmt(2, 5'd2, OP_BLT));
        emit(ifmt(16'h94, 5'd4, 5'd0, OP_STI));
        emit(jfmt(BASE + 32'd80, 1'b1));
        emit(ifmt(16'h95, 5'd31, 5'd0, OP_ST));    // Return lands here
        emit(HLT);
        pc_idx = 20;
        emit(ifmt(16'h96, 5'd6, 5'd0, OP_STI));
        emit(ifmt(16'd0, 5'd31, 5'd0, OP_JALR));
        expect_store(32'h240, 3 * 32'h10);
        expect_store(32'h248, 32'd2);
        expect_store(32'h250, 32'd4);
        expect_store(32'h258, 32'd6);
        expect_store(32'h254, BASE + 4 * 16);
    endtask

    task automatic build_fault();
        start_program();
        emit(ifmt(16'h98, 5'd9, 5'd0, OP_STI));
        emit(32'h0000_0000);
        expect_store(32'h260, 32'd9);
    endtask

    task automatic run_program(input string name, input logic exp_fault);
        int t;
        @(posedge clk);
        #1;
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;
        check_word({name, " reset addr"}, BASE, addr);
        assert (cs && !we && !halted && !fault)
            else fail_with({"No clean fetch request after reset in ", name});
        t = 0;
        while (!halted) begin
            @(posedge clk);
            #1;
            t++;
            if (t > 5000) fail_with({"Timeout waiting for halted in ", name});
        end
        check_word({name, " fault"}, word_t'(exp_fault), word_t'(fault));
        repeat (20) @(posedge clk);   // cs must stay low meanwhile
        check_word({name, " store count"}, exp_addr.size(), mem_i.log_count);
        foreach (exp_addr[k]) begin
            check_word($sformatf("%s store %0d addr", name, k), exp_addr[k], mem_i.log_addr[k]);
            check_word($sformatf("%s store %0d data", name, k), exp_data[k], mem_i.log_data[k]);
        end
    endtask

    initial begin
        rst      = 1'b1;
        stall_en = 1'b0;
        for (int pass = 0; pass < 2; pass++) begin
            stall_en = (pass == 1);     // Second pass with rdy stalls
            build_alu();
            run_program(pass ? "alu stalled" : "alu", 1'b0);
            build_mem();
            run_program(pass ? "mem stalled" : "mem", 1'b0);
            build_branch();
            run_program(pass ? "branch stalled" : "branch", 1'b0);
        end
        stall_en = 1'b0;
        build_fault();
        run_program("unknown encoding", 1'b1);
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+hdl
hdl/limn_pkg.sv
hdl/limn_decode.sv
hdl/limn_regfile.sv
hdl/limn_alu.sv
hdl/limn_branch.sv
hdl/limn_core.sv
tests/tb_limn_mem.sv
tests/tb_limn_core.sv

//--- Makefile
TOP := tb_limn_core

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f all.f --top-module $(TOP) --Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
